// File: list.f
design/cpuIntPkg.sv
design/ccCtrlIf.sv
design/interruptStateMachine.sv
design/programCounter.sv
design/conditionCodeBank.sv
design/intControlUnit.sv
testbench/intControlUnitTb.sv

// File: Bender.yml
package:
  name: int_control_unit

sources:
  - design/cpuIntPkg.sv
  - design/ccCtrlIf.sv
  - design/interruptStateMachine.sv
  - design/programCounter.sv
  - design/conditionCodeBank.sv
  - design/intControlUnit.sv
  - target: test
    files:
      - testbench/intControlUnitTb.sv

// File: testbench/intControlUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module intControlUnitTb;

	import cpuIntPkg::*;

	localparam int RESET_CYCLES  = 10;
	localparam int RANDOM_CYCLES = 1500;
	// Roughly twice the length of all tests together
	localparam int MAX_CYCLES    = 4000;

	logic                CLK;
	logic                RESET;
	logic                commit;
	logic                retiOp;
	logic                eiOp;
	logic                diOp;
	logic                int0;
	logic                int1;
	logic [CC_WIDTH-1:0] ccIn;
	logic [PC_WIDTH-1:0] pc;
	logic [CC_WIDTH-1:0] cc;

	// Reference model state
	intStateT            mState;
	pcSelT               mPcSel;
	logic                mEnable;
	logic                mLd0;
	logic                mLd1;
	logic [PC_WIDTH-1:0] mPc;
	logic [PC_WIDTH-1:0] mSaved0;
	logic [PC_WIDTH-1:0] mSaved1;
	logic [CC_WIDTH-1:0] mCcRun;
	logic [CC_WIDTH-1:0] mCc0;
	logic [CC_WIDTH-1:0] mCc1;

	string               testName;
	int                  errors;
	int                  testErrors;
	int                  testsPassed;
	int                  testsFailed;
	int                  cycles;
	logic [PC_WIDTH-1:0] base;
	int                  op;

	intControlUnit u_intControlUnit (
		.CLK    (CLK),
		.RESET  (RESET),
		.commit (commit),
		.retiOp (retiOp),
		.eiOp   (eiOp),
		.diOp   (diOp),
		.int0   (int0),
		.int1   (int1),
		.ccIn   (ccIn),
		.pc     (pc),
		.cc     (cc)
	);

	always #2 CLK = ~CLK;

	function automatic logic [CC_WIDTH-1:0] expectedCc();
		case (mState)
			RUN:               return mCcRun;
			VEC1, RUN1, RETI1: return mCc1;
			default:           return mCc0;
		endcase
	endfunction

	// One committed instruction through the model
	function void stepModel(input logic r, input logic e, input logic d, input logic i0,
			input logic i1, input logic [CC_WIDTH-1:0] v);
		intStateT            nxt;
		logic [PC_WIDTH-1:0] inc;
		inc = mPc + 1'b1;
		if (mState == RUN) mCcRun = v;
		else if (mState inside {VEC1, RUN1, RETI1}) mCc1 = v;
		else mCc0 = v;
		// New pc uses the saved addresses from before this commit
		case (mPcSel)
			INTV0:   mPc = VECTOR0;
			INTV1:   mPc = VECTOR1;
			INTR0:   mPc = mSaved0;
			INTR1:   mPc = mSaved1;
			default: mPc = inc;
		endcase
		if (mLd0) mSaved0 = inc;
		if (mLd1) mSaved1 = inc;
		nxt = mState;
		case (mState)
			RUN:     nxt = i0 ? VEC0 : ((i1 && mEnable) ? VEC1 : RUN);
			VEC0:    nxt = RUN0;
			VEC1:    nxt = i0 ? VEC1_0 : RUN1;
			VEC1_0:  nxt = RUN1_0;
			RUN0:    nxt = r ? RETI0 : RUN0;
			RUN1:    nxt = i0 ? VEC1_0 : (r ? RETI1 : RUN1);
			RUN1_0:  nxt = r ? RETI1_0 : RUN1_0;
			RETI0:   nxt = RUN;
			RETI1:   nxt = i0 ? VEC0 : RUN;
			RETI1_0: nxt = RUN1;
			default: nxt = RUN;
		endcase
		mState = nxt;
		mLd0   = (nxt == VEC0) || (nxt == VEC1_0);
		mLd1   = (nxt == VEC1);
		if (mLd0) mPcSel = INTV0;
		else if (mLd1) mPcSel = INTV1;
		else if (nxt == RETI0 || nxt == RETI1_0) mPcSel = INTR0;
		else if (nxt == RETI1) mPcSel = INTR1;
		else mPcSel = NEXT;
		if (e) mEnable = 1'b1;
		else if (d) mEnable = 1'b0;
	endfunction

	always @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			mState  = RUN;
			mPcSel  = NEXT;
			mEnable = 1'b0;
			mLd0    = 1'b0;
			mLd1    = 1'b0;
			mPc     = RESET_PC;
			mSaved0 = '0;
			mSaved1 = '0;
			mCcRun  = '0;
			mCc0    = '0;
			mCc1    = '0;
		end else if (commit) begin
			stepModel(retiOp, eiOp, diOp, int0, int1, ccIn);
		end
	end

	task automatic checkValue(input string label, input logic [7:0] expected,
			input logic [7:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("ERR %s %s expected %0h actual %0h", testName, label, expected, actual);
		end
	endtask

	// Outputs are settled half a period after the edge
	always @(negedge CLK) begin
		if (!RESET) begin
			checkValue("pc", mPc, pc);
			checkValue("cc", expectedCc(), cc);
		end
	end

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, the tests did not finish", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic stepCycle(input logic c, input logic r, input logic e, input logic d,
			input logic i0, input logic i1, input logic [CC_WIDTH-1:0] v);
		commit = c;
		retiOp = r;
		eiOp   = e;
		diOp   = d;
		int0   = i0;
		int1   = i1;
		ccIn   = v;
		@(posedge CLK);
		#0.5;
	endtask

	task automatic commitStep(input logic r, input logic e, input logic d, input logic i0,
			input logic i1, input logic [CC_WIDTH-1:0] v);
		stepCycle(1'b1, r, e, d, i0, i1, v);
	endtask

	task automatic startTest(input string name);
		testName   = name;
		testErrors = errors;
	endtask

	task automatic finishTest();
		if (errors == testErrors) begin
			testsPassed++;
			$display("Test %s: ok", testName);
		end else begin
			testsFailed++;
			$display("Test %s: %0d mismatches", testName, errors - testErrors);
		end
	endtask

	initial begin
		void'($urandom(39));
		CLK         = 1'b0;
		RESET       = 1'b1;
		errors      = 0;
		testsPassed = 0;
		testsFailed = 0;
		cycles      = 0;
		testName    = "reset";
		{commit, retiOp, eiOp, diOp, int0, int1} = '0;
		ccIn = '0;
		repeat (RESET_CYCLES) @(posedge CLK);
		#0.5;
		RESET = 1'b0;

		startTest("countUp");
		for (int i = 0; i < 8; i++) begin
			commitStep(0, 0, 0, 0, 0, CC_WIDTH'(i));
		end
		// Without commit nothing moves, not even on int0
		repeat (3) stepCycle(0, 1, 1, 0, 1, 1, 4'hF);
		checkValue("pc after count", RESET_PC + 8, pc);
		checkValue("run cc", 4'h7, cc);
		finishTest();

		startTest("int1Mask");
		base = mPc;
		repeat (3) commitStep(0, 0, 0, 0, 1, 4'h2);
		checkValue("pc while masked", base + 3, pc);
		commitStep(0, 1, 0, 0, 0, 4'h3);
		base = mPc;
		commitStep(0, 0, 0, 0, 1, 4'h3);
		commitStep(0, 0, 0, 0, 0, 4'h9);
		checkValue("pc at vector1", VECTOR1, pc);
		checkValue("int1 cc", 4'h9, cc);
		commitStep(0, 0, 0, 0, 0, 4'hA);
		repeat (2) stepCycle(0, 1, 0, 0, 0, 0, 4'h1);
		commitStep(1, 0, 0, 0, 0, 4'hB);
		commitStep(0, 0, 0, 0, 0, 4'hC);
		checkValue("pc after return", base + 2, pc);
		checkValue("run cc after return", 4'h3, cc);
		commitStep(0, 0, 1, 0, 0, 4'h5);
		base = mPc;
		repeat (3) commitStep(0, 0, 0, 0, 1, 4'h6);
		checkValue("pc after disable", base + 3, pc);
		finishTest();

		startTest("int0Return");
		base = mPc;
		commitStep(0, 0, 0, 1, 0, 4'h7);
		commitStep(0, 0, 0, 0, 0, 4'h1);
		checkValue("pc at vector0", VECTOR0, pc);
		checkValue("int0 cc", 4'h1, cc);
		commitStep(0, 0, 0, 0, 0, 4'h2);
		stepCycle(0, 0, 0, 0, 0, 0, 4'h0);
		commitStep(1, 0, 0, 0, 0, 4'h3);
		commitStep(0, 0, 0, 0, 0, 4'h4);
		checkValue("pc after return", base + 2, pc);
		checkValue("run cc kept", 4'h7, cc);
		finishTest();

		startTest("nested");
		commitStep(0, 1, 0, 0, 0, 4'hE);
		base = mPc;
		commitStep(0, 0, 0, 0, 1, 4'h1);
		commitStep(0, 0, 0, 0, 0, 4'h2);
		commitStep(0, 0, 0, 0, 0, 4'h3);
		commitStep(0, 0, 0, 1, 0, 4'h4);
		commitStep(0, 0, 0, 0, 0, 4'h5);
		checkValue("pc at nested vector0", VECTOR0, pc);
		checkValue("nested int0 cc", 4'h5, cc);
		commitStep(1, 0, 0, 0, 0, 4'h6);
		commitStep(0, 0, 0, 0, 0, 4'h7);
		checkValue("pc back in int1", VECTOR1 + 3, pc);
		checkValue("int1 cc kept", 4'h4, cc);
		commitStep(1, 0, 0, 0, 0, 4'h8);
		commitStep(0, 0, 0, 0, 0, 4'h9);
		checkValue("pc back in run", base + 2, pc);
		checkValue("run cc kept", 4'h1, cc);
		finishTest();

		startTest("random");
		for (int i = 0; i < RANDOM_CYCLES; i++) begin
			op = $urandom % 8;
			stepCycle(($urandom % 4) != 0, op >= 6, op == 0, op == 1,
				($urandom % 16) == 0, ($urandom % 6) == 0, CC_WIDTH'($urandom));
		end
		finishTest();

		$display("Tests passed %0d, failed %0d, mismatches %0d", testsPassed, testsFailed,
			errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: design/intControlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module intControlUnit (
	input  logic                            CLK,
	input  logic                            RESET,
	input  logic                            commit,
	input  logic                            retiOp,
	input  logic                            eiOp,
	input  logic                            diOp,
	input  logic                            int0,
	input  logic                            int1,
	input  logic [cpuIntPkg::CC_WIDTH-1:0]  ccIn,
	output logic [cpuIntPkg::PC_WIDTH-1:0]  pc,
	output logic [cpuIntPkg::CC_WIDTH-1:0]  cc
);

	import cpuIntPkg::*;

	pcSelT pcSel;
	logic  ldInt0;
	logic  ldInt1;

	// Condition-code bank control
	ccCtrlIf ccCtrl ();

	interruptStateMachine u_interruptStateMachine (
		.CLK    (CLK),
		.RESET  (RESET),
		.commit (commit),
		.retiOp (retiOp),
		.eiOp   (eiOp),
		.diOp   (diOp),
		.int0   (int0),
		.int1   (int1),
		.pcSel  (pcSel),
		.ldInt0 (ldInt0),
		.ldInt1 (ldInt1),
		.ccCtrl (ccCtrl.ctrl)
	);

	programCounter u_programCounter (
		.CLK    (CLK),
		.RESET  (RESET),
		.commit (commit),
		.pcSel  (pcSel),
		.ldInt0 (ldInt0),
		.ldInt1 (ldInt1),
		.pc     (pc)
	);

	conditionCodeBank u_conditionCodeBank (
		.CLK    (CLK),
		.RESET  (RESET),
		.commit (commit),
		.ccIn   (ccIn),
		.ccCtrl (ccCtrl.bank),
		.cc     (cc)
	);

endmodule

`default_nettype wire

// File: design/conditionCodeBank.sv
`timescale 1ns/1ps
`default_nettype none

module conditionCodeBank (
	input  logic                            CLK,
	input  logic                            RESET,
	input  logic                            commit,
	input  logic [cpuIntPkg::CC_WIDTH-1:0]  ccIn,
	ccCtrlIf.bank                           ccCtrl,
	output logic [cpuIntPkg::CC_WIDTH-1:0]  cc
);

	import cpuIntPkg::*;

	// One register for normal code and one per interrupt level
	logic [CC_WIDTH-1:0] ccRun;
	logic [CC_WIDTH-1:0] ccInt0;
	logic [CC_WIDTH-1:0] ccInt1;

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			ccRun  <= '0;
			ccInt0 <= '0;
			ccInt1 <= '0;
		end else if (commit) begin
			if (ccCtrl.enRun) begin
				ccRun <= ccIn;
			end
			if (ccCtrl.en0) begin
				ccInt0 <= ccIn;
			end
			if (ccCtrl.en1) begin
				ccInt1 <= ccIn;
			end
		end
	end

	always_comb begin
		case (ccCtrl.ccSel)
			CC_INT0: cc = ccInt0;
			CC_INT1: cc = ccInt1;
			default: cc = ccRun;
		endcase
	end

	// Writes never go to a register other than the one being read
	assert property (@(posedge CLK) disable iff (RESET)
		commit |-> (ccCtrl.enRun == (ccCtrl.ccSel == CC_RUN))
			&& (ccCtrl.en0 == (ccCtrl.ccSel == CC_INT0))
			&& (ccCtrl.en1 == (ccCtrl.ccSel == CC_INT1)));

endmodule

`default_nettype wire

// File: design/programCounter.sv
`timescale 1ns/1ps
`default_nettype none

module programCounter (
	input  logic                            CLK,
	input  logic                            RESET,
	input  logic                            commit,
	input  cpuIntPkg::pcSelT                pcSel,
	input  logic                            ldInt0,
	input  logic                            ldInt1,
	output logic [cpuIntPkg::PC_WIDTH-1:0]  pc
);

	import cpuIntPkg::*;

	logic [PC_WIDTH-1:0] pcInc;
	logic [PC_WIDTH-1:0] pcNext;

	// Return addresses for the two interrupt levels
	logic [PC_WIDTH-1:0] savedPc0;
	logic [PC_WIDTH-1:0] savedPc1;

	assign pcInc = pc + PC_WIDTH'(1);

	always_comb begin
		case (pcSel)
			INTV0:   pcNext = VECTOR0;
			INTV1:   pcNext = VECTOR1;
			INTR0:   pcNext = savedPc0;
			INTR1:   pcNext = savedPc1;
			default: pcNext = pcInc;
		endcase
	end

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			pc       <= RESET_PC;
			savedPc0 <= '0;
			savedPc1 <= '0;
		end else if (commit) begin
			// Save the address that would have run next
			if (ldInt0) begin
				savedPc0 <= pcInc;
			end
			if (ldInt1) begin
				savedPc1 <= pcInc;
			end
			pc <= pcNext;
		end
	end

	// The INT0 save strobe and the INT0 vector come together from the FSM
	assert property (@(posedge CLK) disable iff (RESET)
		(commit && ldInt0) |=> (pc == VECTOR0));

endmodule

`default_nettype wire

// File: design/interruptStateMachine.sv
`timescale 1ns/1ps
`default_nettype none

module interruptStateMachine (
	input  logic              CLK,
	input  logic              RESET,
	input  logic              commit,
	input  logic              retiOp,
	input  logic              eiOp,
	input  logic              diOp,
	input  logic              int0,
	input  logic              int1,
	output cpuIntPkg::pcSelT  pcSel,
	output logic              ldInt0,
	output logic              ldInt1,
	ccCtrlIf.ctrl             ccCtrl
);

	import cpuIntPkg::*;

	intStateT state;
	intStateT stateNext;
	pcSelT    pcSelNext;
	logic     ldInt0Next;
	logic     ldInt1Next;

	// INT1 mask that EI sets and DI clears
	logic     intEnable;

	// INT0 always wins over INT1 and RETI
	always_comb begin
		case (state)
			RUN: begin
				if (int0) begin
					stateNext = VEC0;
				end else if (int1 && intEnable) begin
					stateNext = VEC1;
				end else begin
					stateNext = RUN;
				end
			end
			VEC0: begin
				stateNext = RUN0;
			end
			VEC1: begin
				if (int0) begin
					stateNext = VEC1_0;
				end else begin
					stateNext = RUN1;
				end
			end
			VEC1_0: begin
				stateNext = RUN1_0;
			end
			RUN0: begin
				if (retiOp) begin
					stateNext = RETI0;
				end else begin
					stateNext = RUN0;
				end
			end
			RUN1: begin
				if (int0) begin
					stateNext = VEC1_0;
				end else if (retiOp) begin
					stateNext = RETI1;
				end else begin
					stateNext = RUN1;
				end
			end
			RUN1_0: begin
				if (retiOp) begin
					stateNext = RETI1_0;
				end else begin
					stateNext = RUN1_0;
				end
			end
			RETI0: begin
				stateNext = RUN;
			end
			RETI1: begin
				if (int0) begin
					stateNext = VEC0;
				end else begin
					stateNext = RUN;
				end
			end
			RETI1_0: begin
				stateNext = RUN1;
			end
			default: begin
				stateNext = RUN;
			end
		endcase
	end

	// Bank control follows the current state only
	always_comb begin
		case (state)
			RUN:               ccCtrl.ccSel = CC_RUN;
			VEC1, RUN1, RETI1: ccCtrl.ccSel = CC_INT1;
			default:           ccCtrl.ccSel = CC_INT0;
		endcase
	end

	// Write enables decoded straight from the state
	assign ccCtrl.enRun = (state == RUN);
	assign ccCtrl.en0   = (state inside {VEC0, VEC1_0, RUN0, RUN1_0, RETI0, RETI1_0});
	assign ccCtrl.en1   = (state inside {VEC1, RUN1, RETI1});

	// Save strobes mark the vector states being entered
	assign ldInt0Next = (stateNext inside {VEC0, VEC1_0});
	assign ldInt1Next = (stateNext == VEC1);

	// PC source is decoded from the state being entered
	always_comb begin
		pcSelNext = NEXT;
		case (stateNext)
			VEC0, VEC1_0: begin
				pcSelNext = INTV0;
			end
			VEC1: begin
				pcSelNext = INTV1;
			end
			RETI0, RETI1_0: begin
				pcSelNext = INTR0;
			end
			RETI1: begin
				pcSelNext = INTR1;
			end
			default: begin
				pcSelNext = NEXT;
			end
		endcase
	end

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			state     <= RUN;
			pcSel     <= NEXT;
			ldInt0    <= 1'b0;
			ldInt1    <= 1'b0;
			intEnable <= 1'b0;
		end else if (commit) begin
			state  <= stateNext;
			pcSel  <= pcSelNext;
			ldInt0 <= ldInt0Next;
			ldInt1 <= ldInt1Next;
			if (eiOp) begin
				intEnable <= 1'b1;
			end else if (diOp) begin
				intEnable <= 1'b0;
			end
		end
	end

	// Exactly one bank register is written on any commit
	assert property (@(posedge CLK) disable iff (RESET)
		$onehot({ccCtrl.enRun, ccCtrl.en0, ccCtrl.en1}));

	// The PC unit can only save one return address per commit
	assert property (@(posedge CLK) disable iff (RESET)
		!(ldInt0 && ldInt1));

	assert property (@(posedge CLK) disable iff (RESET)
		state inside {RUN, VEC0, VEC1, VEC1_0, RUN0, RUN1, RUN1_0, RETI0, RETI1, RETI1_0});

endmodule

`default_nettype wire

// File: design/ccCtrlIf.sv
`timescale 1ns/1ps
`default_nettype none

interface ccCtrlIf;

	import cpuIntPkg::*;

	// Read select for the condition-code bank
	ccSelT ccSel;

	// One write enable per banked register
	logic enRun;
	logic en0;
	logic en1;

	modport ctrl (
		output ccSel,
		output enRun,
		output en0,
		output en1
	);

	modport bank (
		input ccSel,
		input enRun,
		input en0,
		input en1
	);

endinterface

`default_nettype wire

// File: design/cpuIntPkg.sv
`default_nettype none

package cpuIntPkg;

	// Datapath widths
	localparam int PC_WIDTH = 8;
	localparam int CC_WIDTH = 4;

	// Fixed program addresses
	localparam logic [PC_WIDTH-1:0] RESET_PC = 8'h00;
	localparam logic [PC_WIDTH-1:0] VECTOR0  = 8'h04;
	localparam logic [PC_WIDTH-1:0] VECTOR1  = 8'h08;

	// Privileged interrupt states
	// VEC states last one commit and load the vector
	// RETI states last one commit and load the return address
	// The _0 suffix marks INT0 nested inside an INT1 handler
	typedef enum logic [3:0] {
		RUN     = 4'd0,
		VEC0    = 4'd1,
		VEC1    = 4'd2,
		VEC1_0  = 4'd3,
		RUN0    = 4'd4,
		RUN1    = 4'd5,
		RUN1_0  = 4'd6,
		RETI0   = 4'd7,
		RETI1   = 4'd8,
		RETI1_0 = 4'd9
	} intStateT;

	// Source of the next program counter value
	typedef enum logic [2:0] {
		NEXT  = 3'd0,
		INTV0 = 3'd1,
		INTV1 = 3'd2,
		INTR0 = 3'd3,
		INTR1 = 3'd4
	} pcSelT;

	// Active condition-code register
	typedef enum logic [1:0] {
		CC_RUN  = 2'd0,
		CC_INT0 = 2'd1,
		CC_INT1 = 2'd2
	} ccSelT;

endpackage

`default_nettype wire
